// File: src/gpuRenderPkg.sv
/* GPU rectangle render
   Shared types and constants */

package gpuRenderPkg;

	// ----------------------------------------
	// VRAM geometry
	// ----------------------------------------
	localparam int PAIR_BITS    = 1;  // Two pixels per scan step
	localparam int BLOCK_X_BITS = 4;  // 16 pixels of one row per VRAM block
	localparam int VRAM_Y_BITS  = 9;  // 512 rows
	localparam int VRAM_X_BITS  = 10; // 1024 pixels per row

	// ----------------------------------------
	// Vector types
	// ----------------------------------------
	typedef logic signed [11:0] coord_t;             // Vertex coordinate, -2048..2047
	typedef logic [VRAM_X_BITS-1:0] drawCoord_t;     // Draw area coordinate

	// Block address is { row[8:0], col[9:4] }
	typedef logic [VRAM_Y_BITS+VRAM_X_BITS-BLOCK_X_BITS-1:0] blockAdr_t;
	typedef logic [BLOCK_X_BITS-PAIR_BITS-1:0] pairIdx_t; // Pair inside block, col[3:1]
	typedef logic [1:0] maskPair_t;                       // Bit 0 is the even pixel

	// ----------------------------------------
	// Enums
	// ----------------------------------------
	typedef enum logic [1:0] {
		EV_NONE        = 2'd0,
		EV_NEW_BLOCK   = 2'd1, // First block touched by the primitive
		EV_OTHER_BLOCK = 2'd2, // Moved to a different block
		EV_FLUSH_LAST  = 2'd3  // Primitive done, flush pending block
	} blockEvent_t;

	typedef enum logic [2:0] {
		RENDER_WAIT    = 3'd0,
		RECT_START     = 3'd1,
		RECT_SCAN_LINE = 3'd2,
		FLUSH_COMPLETE = 3'd3
	} renderState_t;

	// ----------------------------------------
	// Structs
	// ----------------------------------------
	typedef struct packed {
		coord_t x0, y0, x1, y1; // Inclusive corners
	} rect_t;

	typedef struct packed {
		drawCoord_t x0, y0, x1, y1; // Inclusive
	} drawArea_t;

	typedef struct packed {
		drawCoord_t left;   // Even aligned
		drawCoord_t top;
		drawCoord_t right;  // Exact, may be odd
		drawCoord_t bottom;
		logic       reject; // Nothing to draw
	} clipBox_t;

	typedef struct packed {
		logic      read;
		blockAdr_t adr;
		pairIdx_t  pair;
	} stencilReq_t;

	typedef struct packed {
		logic        writeL;
		logic        writeR;
		drawCoord_t  x;     // Even pixel of the pair
		drawCoord_t  y;
		blockEvent_t ev;
	} pixelWrite_t;

endpackage

// File: src/rectClipDecode.sv
/* Rectangle clip decode */

module rectClipDecode (
	input  logic                    i_clk,
	input  logic                    i_arstN,
	input  logic                    i_start,    // Only pulsed while idle
	input  gpuRenderPkg::rect_t     i_rect,
	input  gpuRenderPkg::drawArea_t i_drawArea,
	output gpuRenderPkg::clipBox_t  o_box,
	output gpuRenderPkg::drawCoord_t o_drawLeft // Clipped left edge, not aligned
);

	// Draw area widened to the signed vertex range
	gpuRenderPkg::coord_t daX0, daY0, daX1, daY1;
	gpuRenderPkg::coord_t clipL, clipT, clipR, clipB;
	logic isInverted, isEmpty;
	logic rejectReg;

	assign daX0 = gpuRenderPkg::coord_t'({2'b00, i_drawArea.x0});
	assign daY0 = gpuRenderPkg::coord_t'({2'b00, i_drawArea.y0});
	assign daX1 = gpuRenderPkg::coord_t'({2'b00, i_drawArea.x1});
	assign daY1 = gpuRenderPkg::coord_t'({2'b00, i_drawArea.y1});

	// ----------------------------------------
	// Intersection, signed compares
	// ----------------------------------------
	assign clipL = (i_rect.x0 > daX0) ? i_rect.x0 : daX0; // Max of left edges
	assign clipT = (i_rect.y0 > daY0) ? i_rect.y0 : daY0;
	assign clipR = (i_rect.x1 < daX1) ? i_rect.x1 : daX1; // Min of right edges
	assign clipB = (i_rect.y1 < daY1) ? i_rect.y1 : daY1;

	assign isInverted = (i_rect.x0 > i_rect.x1) | (i_rect.y0 > i_rect.y1);
	assign isEmpty    = (clipL > clipR) | (clipT > clipB); // Also catches a rect outside the area

	// Box values, only meaningful when not rejected
	always_ff @(posedge i_clk) begin
		if (i_start) begin
			o_box.left   <= {clipL[9:1], 1'b0}; // Scan starts on an even pixel
			o_box.top    <= clipT[9:0];
			o_box.right  <= clipR[9:0];         // Kept exact to drop the odd pixel
			o_box.bottom <= clipB[9:0];
			o_drawLeft   <= clipL[9:0];
		end
	end

	// Reject flag
	always_ff @(posedge i_clk or negedge i_arstN) begin
		if (!i_arstN) begin
			rejectReg <= 1'b1;
		end else if (i_start) begin
			rejectReg <= isInverted | isEmpty;
		end
	end

	assign o_box.reject = rejectReg;

endmodule

// File: src/rectScanFsm.sv
/* Rectangle scan FSM */

module rectScanFsm (
	input  logic                     i_clk,
	input  logic                     i_arstN,
	input  logic                     i_start,
	input  gpuRenderPkg::clipBox_t   i_box,
	input  gpuRenderPkg::drawCoord_t i_drawLeft,
	input  logic                     i_checkMask,
	input  logic                     i_memBusy,
	input  gpuRenderPkg::maskPair_t  i_stencilValue, // Answer to last cycle's read
	output gpuRenderPkg::stencilReq_t o_stencilReq,
	output logic                     o_writeL,
	output logic                     o_writeR,
	output gpuRenderPkg::drawCoord_t o_pairX,
	output gpuRenderPkg::drawCoord_t o_pairY,
	output logic                     o_firstPrim,    // Primitive not yet scanning
	output logic                     o_flush,
	output logic                     o_busy,
	output logic                     o_renderInactiveNextCycle
);

	gpuRenderPkg::renderState_t currState, nextState;

	// One extra bit so the pair after x=1022 does not wrap to 0
	logic [gpuRenderPkg::VRAM_X_BITS:0] scanX, nextX;
	gpuRenderPkg::drawCoord_t scanY, nextY;

	logic readSig;
	logic flushSent;
	logic pairInLine, lastLine;
	logic insideL, insideR;
	logic maskOkL, maskOkR;

	// ----------------------------------------
	// Pair membership
	// ----------------------------------------
	assign pairInLine = (scanX <= {1'b0, i_box.right}); // Even pixel not past right edge
	assign lastLine   = (scanY == i_box.bottom);
	assign insideL    = (scanX[gpuRenderPkg::VRAM_X_BITS-1:0] >= i_drawLeft); // Odd left edge
	assign insideR    = (scanX < {1'b0, i_box.right});  // Odd pixel still <= right

	// Stencil bit set means protected pixel
	assign maskOkL = !i_checkMask | !i_stencilValue[0];
	assign maskOkR = !i_checkMask | !i_stencilValue[1];

	// ----------------------------------------
	// Next state and scan decision
	// ----------------------------------------
	always_comb begin
		nextState = currState;
		nextX     = scanX;
		nextY     = scanY;
		readSig   = 1'b0;
		o_writeL  = 1'b0;
		o_writeR  = 1'b0;
		o_flush   = 1'b0;

		case (currState)
		gpuRenderPkg::RENDER_WAIT: begin
			if (i_start) begin
				nextState = gpuRenderPkg::RECT_START;
			end
		end
		gpuRenderPkg::RECT_START: begin
			if (i_box.reject) begin
				nextState = gpuRenderPkg::RENDER_WAIT; // Empty or inverted, done
			end else begin
				nextState = gpuRenderPkg::RECT_SCAN_LINE;
				nextX     = {1'b0, i_box.left};
				nextY     = i_box.top;
				readSig   = 1'b1;                      // Stencil of the first pair
			end
		end
		gpuRenderPkg::RECT_SCAN_LINE: begin
			readSig = 1'b1;                            // Repeats for the same pair on stall
			if (!i_memBusy) begin
				if (pairInLine) begin
					o_writeL = insideL & maskOkL;
					o_writeR = insideR & maskOkR;
					nextX    = scanX + 2'd2;
				end else if (lastLine) begin
					nextState = gpuRenderPkg::FLUSH_COMPLETE;
					readSig   = 1'b0;
				end else begin
					nextX = {1'b0, i_box.left};        // Line wrap, one idle cycle
					nextY = scanY + 1'b1;
				end
			end
		end
		gpuRenderPkg::FLUSH_COMPLETE: begin
			if (flushSent) begin
				nextState = gpuRenderPkg::RENDER_WAIT;
			end else begin
				o_flush = 1'b1;                        // Exactly once per primitive
			end
		end
		default: begin
			nextState = gpuRenderPkg::RENDER_WAIT;
		end
		endcase
	end

	// ----------------------------------------
	// State and position
	// ----------------------------------------
	always_ff @(posedge i_clk or negedge i_arstN) begin
		if (!i_arstN) begin
			currState <= gpuRenderPkg::RENDER_WAIT;
			scanX     <= '0;
			scanY     <= '0;
			flushSent <= 1'b0;
		end else begin
			currState <= nextState;
			scanX     <= nextX;
			scanY     <= nextY;
			flushSent <= o_flush;
		end
	end

	// Read always targets the pair current next cycle
	assign o_stencilReq.read = readSig;
	assign o_stencilReq.adr  = {nextY[gpuRenderPkg::VRAM_Y_BITS-1:0],
		nextX[gpuRenderPkg::VRAM_X_BITS-1:gpuRenderPkg::BLOCK_X_BITS]};
	assign o_stencilReq.pair = nextX[gpuRenderPkg::BLOCK_X_BITS-1:gpuRenderPkg::PAIR_BITS];

	assign o_pairX     = scanX[gpuRenderPkg::VRAM_X_BITS-1:0];
	assign o_pairY     = scanY;
	assign o_firstPrim = (currState == gpuRenderPkg::RENDER_WAIT) |
		(currState == gpuRenderPkg::RECT_START);
	assign o_busy      = (currState != gpuRenderPkg::RENDER_WAIT);
	assign o_renderInactiveNextCycle = (currState != gpuRenderPkg::RENDER_WAIT) &&
		(nextState == gpuRenderPkg::RENDER_WAIT);

endmodule

// File: src/blockTracker.sv
/* VRAM block tracker */

module blockTracker (
	input  logic                      i_clk,
	input  logic                      i_arstN,
	input  logic                      i_writeL,
	input  logic                      i_writeR,
	input  gpuRenderPkg::drawCoord_t  i_pairX,
	input  gpuRenderPkg::drawCoord_t  i_pairY,
	input  logic                      i_firstPrim, // Arms the new-block tag
	input  logic                      i_flush,
	output gpuRenderPkg::pixelWrite_t o_pixelWrite
);

	gpuRenderPkg::blockAdr_t currAdr, prevAdr;
	gpuRenderPkg::blockEvent_t blockEv;
	logic anyWrite;
	logic pendingFirst; // Still set means nothing written yet

	assign anyWrite = i_writeL | i_writeR;
	assign currAdr  = {i_pairY[gpuRenderPkg::VRAM_Y_BITS-1:0],
		i_pairX[gpuRenderPkg::VRAM_X_BITS-1:gpuRenderPkg::BLOCK_X_BITS]};

	// ----------------------------------------
	// Event select
	// ----------------------------------------
	always_comb begin
		blockEv = gpuRenderPkg::EV_NONE;
		if (anyWrite) begin
			if (pendingFirst)
				blockEv = gpuRenderPkg::EV_NEW_BLOCK;
			else if (currAdr != prevAdr)
				blockEv = gpuRenderPkg::EV_OTHER_BLOCK;
		end else if (i_flush && !pendingFirst) begin
			blockEv = gpuRenderPkg::EV_FLUSH_LAST; // Only if a block is open
		end
	end

	// Last written block
	always_ff @(posedge i_clk) begin
		if (anyWrite)
			prevAdr <= currAdr;
	end

	always_ff @(posedge i_clk or negedge i_arstN) begin
		if (!i_arstN) begin
			pendingFirst <= 1'b1;
			o_pixelWrite <= '0;           // EV_NONE, no writes
		end else begin
			if (i_firstPrim)
				pendingFirst <= 1'b1;
			else if (anyWrite)
				pendingFirst <= 1'b0;

			o_pixelWrite.writeL <= i_writeL;
			o_pixelWrite.writeR <= i_writeR;
			o_pixelWrite.x      <= i_pairX;
			o_pixelWrite.y      <= i_pairY;
			o_pixelWrite.ev     <= blockEv;
		end
	end

endmodule

// File: src/gpuRectRender.sv
/* GPU rectangle render top */

module gpuRectRender (
	input  logic                      i_clk,
	input  logic                      i_arstN,
	input  logic                      i_start,
	input  gpuRenderPkg::rect_t       i_rect,
	input  gpuRenderPkg::drawArea_t   i_drawArea,
	input  logic                      i_checkMask,
	input  logic                      i_memBusy,
	input  gpuRenderPkg::maskPair_t   i_stencilValue,
	output gpuRenderPkg::stencilReq_t o_stencilReq,
	output gpuRenderPkg::pixelWrite_t o_pixelWrite,
	output logic                      o_busy,
	output logic                      o_renderInactiveNextCycle
);

	gpuRenderPkg::clipBox_t   clipBox;
	gpuRenderPkg::drawCoord_t drawLeft;
	gpuRenderPkg::drawCoord_t pairX, pairY;
	logic writeL, writeR;
	logic firstPrim, flush;
	logic startIdle;

	assign startIdle = i_start & !o_busy; // Box must stay stable during a scan

	// ----------------------------------------
	// Clip, scan, block tagging
	// ----------------------------------------
	rectClipDecode u_rectClipDecode (
		.i_clk      (i_clk),
		.i_arstN    (i_arstN),
		.i_start    (startIdle),
		.i_rect     (i_rect),
		.i_drawArea (i_drawArea),
		.o_box      (clipBox),
		.o_drawLeft (drawLeft)
	);

	rectScanFsm u_rectScanFsm (
		.i_clk                     (i_clk),
		.i_arstN                   (i_arstN),
		.i_start                   (i_start),
		.i_box                     (clipBox),
		.i_drawLeft                (drawLeft),
		.i_checkMask               (i_checkMask),
		.i_memBusy                 (i_memBusy),
		.i_stencilValue            (i_stencilValue),
		.o_stencilReq              (o_stencilReq),
		.o_writeL                  (writeL),
		.o_writeR                  (writeR),
		.o_pairX                   (pairX),
		.o_pairY                   (pairY),
		.o_firstPrim               (firstPrim),
		.o_flush                   (flush),
		.o_busy                    (o_busy),
		.o_renderInactiveNextCycle (o_renderInactiveNextCycle)
	);

	blockTracker u_blockTracker (
		.i_clk        (i_clk),
		.i_arstN      (i_arstN),
		.i_writeL     (writeL),
		.i_writeR     (writeR),
		.i_pairX      (pairX),
		.i_pairY      (pairY),
		.i_firstPrim  (firstPrim),
		.i_flush      (flush),
		.o_pixelWrite (o_pixelWrite)
	);

endmodule

// File: sim/gpuRectRender_assert.sv
/* Render protocol assertions */

module gpuRectRender_assert (
	input logic                      i_clk,
	input logic                      i_arstN,
	input logic                      i_memBusy,
	input logic                      i_busy,
	input logic                      i_inactive,
	input gpuRenderPkg::pixelWrite_t i_pixelWrite
);

	logic anyWrite;
	logic newSeen;     // New block already tagged in this primitive
	int failCount = 0; // Failed assertions so far

	assign anyWrite = i_pixelWrite.writeL | i_pixelWrite.writeR;

	always_ff @(posedge i_clk or negedge i_arstN) begin
		if (!i_arstN) begin
			newSeen <= 1'b0;
		end else if (i_inactive) begin
			newSeen <= 1'b0;                  // Primitive ends here
		end else if (i_pixelWrite.ev == gpuRenderPkg::EV_NEW_BLOCK) begin
			newSeen <= 1'b1;
		end
	end

	// ----------------------------------------
	// Properties
	// ----------------------------------------
	writeOnlyBusy: assert property (@(posedge i_clk) disable iff (!i_arstN)
		anyWrite |-> i_busy)
		else begin
			$error("pixel write while idle");
			failCount++;
		end

	inactivePulse: assert property (@(posedge i_clk) disable iff (!i_arstN)
		i_inactive |=> !i_inactive && !i_busy)
		else begin
			$error("inactive is not a single pulse");
			failCount++;
		end

	// Stalled decision must not produce a write one cycle later
	noWriteAfterStall: assert property (@(posedge i_clk) disable iff (!i_arstN)
		i_memBusy |=> !anyWrite)
		else begin
			$error("write after a stalled cycle");
			failCount++;
		end

	oneNewBlock: assert property (@(posedge i_clk) disable iff (!i_arstN)
		(i_pixelWrite.ev == gpuRenderPkg::EV_NEW_BLOCK) |-> !newSeen)
		else begin
			$error("second new-block event in one primitive");
			failCount++;
		end

endmodule

bind gpuRectRender gpuRectRender_assert u_gpuRectRenderAssert (
	.i_clk        (i_clk),
	.i_arstN      (i_arstN),
	.i_memBusy    (i_memBusy),
	.i_busy       (o_busy),
	.i_inactive   (o_renderInactiveNextCycle),
	.i_pixelWrite (o_pixelWrite)
);

// File: sim/tbGpuRectRender.sv
/* Rectangle render testbench */

module tbGpuRectRender;

	logic i_clk = 1'b0;
	logic i_arstN, i_start, i_checkMask, i_memBusy;
	gpuRenderPkg::rect_t       i_rect;
	gpuRenderPkg::drawArea_t   i_drawArea;
	gpuRenderPkg::maskPair_t   i_stencilValue;
	gpuRenderPkg::stencilReq_t o_stencilReq;
	gpuRenderPkg::stencilReq_t lastReq = '0; // Read strobed in the previous cycle
	gpuRenderPkg::pixelWrite_t o_pixelWrite;
	logic o_busy, o_renderInactiveNextCycle;

	logic [1023:0] stencilMem [64];          // Rows taken modulo 64
	logic [31:0] rngState = 32'hbefe_4650;
	logic busyMode = 1'b0;                   // Random stalls on
	int cycleCount = 0;
	int cycleLimit = 200;                    // Grows by 3x area per rectangle
	int errors = 0;
	int testErrStart = 0;
	int testsRun = 0;
	int assertFails = 0;
	gpuRenderPkg::pixelWrite_t expQ[$];      // Expected pair writes in scan order

	gpuRectRender i_gpuRectRender (.*);

	always #10 i_clk = ~i_clk;

	always @(posedge i_clk) begin
		cycleCount++;
		if (cycleCount > cycleLimit) begin
			$display("Timeout after %0d cycles, the render never went inactive", cycleCount);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// ----------------------------------------
	// Helpers and stencil model
	// ----------------------------------------
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] t;
		t = s ^ (s << 13);
		t = t ^ (t >> 17);
		return t ^ (t << 5);
	endfunction

	function automatic int maxInt(input int p, input int q);
		return (p > q) ? p : q;
	endfunction

	function automatic int minInt(input int p, input int q);
		return (p < q) ? p : q;
	endfunction

	function automatic logic maskAt(input int x, input int y);
		return stencilMem[y % 64][x];
	endfunction

	always @(posedge i_clk) lastReq <= o_stencilReq;

	// Answer last read, then pick this cycle's stall
	always @(negedge i_clk) begin
		int px;
		int row;
		px  = {lastReq.adr[5:0], lastReq.pair, 1'b0};
		row = lastReq.adr[11:6];
		i_stencilValue = lastReq.read ? {maskAt(px + 1, row), maskAt(px, row)} : 2'b00;
		rngState  = xorshift(rngState);
		i_memBusy = busyMode & (rngState[1:0] == 2'b00); // About one stall in four
	end

	// ----------------------------------------
	// Checks and reference model
	// ----------------------------------------
	task automatic checkPixelWrite(input string name, input gpuRenderPkg::pixelWrite_t exp,
		input gpuRenderPkg::pixelWrite_t act);
		if (act !== exp) begin
			$display("MISMATCH %s expected L%b R%b (%0d,%0d) %s, actual L%b R%b (%0d,%0d) %s",
				name, exp.writeL, exp.writeR, exp.x, exp.y, exp.ev.name(),
				act.writeL, act.writeR, act.x, act.y, act.ev.name());
			errors++;
		end
	endtask

	task automatic checkEvent(input string name, input gpuRenderPkg::blockEvent_t exp,
		input gpuRenderPkg::blockEvent_t act);
		if (act !== exp) begin
			$display("MISMATCH %s expected event %s, actual %s", name, exp.name(), act.name());
			errors++;
		end
	endtask

	// Rows top to bottom, even aligned pairs left to right
	task automatic buildExpected(input gpuRenderPkg::rect_t r, input gpuRenderPkg::drawArea_t a,
		input logic mask);
		int l, t, rt, bt;
		logic wL, wR, first;
		logic [14:0] adr, prevAdr;
		gpuRenderPkg::blockEvent_t ev;
		gpuRenderPkg::pixelWrite_t pw;
		l  = maxInt(r.x0, a.x0);
		t  = maxInt(r.y0, a.y0);
		rt = minInt(r.x1, a.x1);                  // Inverted or outside gives no pairs
		bt = minInt(r.y1, a.y1);
		first = 1'b1;
		prevAdr = '0;
		expQ.delete();
		if (rt >= l && bt >= t) cycleLimit += 3 * (rt - l + 1) * (bt - t + 1);
		for (int y = t; y <= bt; y++) begin
			for (int x = l & ~1; x <= rt; x += 2) begin
				wL = (x >= l) && !(mask && maskAt(x, y));
				wR = (x + 1 <= rt) && !(mask && maskAt(x + 1, y));
				adr = {y[8:0], x[9:4]};
				if (wL || wR) begin
					ev = gpuRenderPkg::EV_NONE;
					if (first) ev = gpuRenderPkg::EV_NEW_BLOCK;
					else if (adr != prevAdr) ev = gpuRenderPkg::EV_OTHER_BLOCK;
					pw = '{wL, wR, x[9:0], y[9:0], ev};
					expQ.push_back(pw);
					first = 1'b0;
					prevAdr = adr;
				end
			end
		end
	endtask

	// ----------------------------------------
	// One rectangle from start to idle
	// ----------------------------------------
	task automatic runRect(input string name, input gpuRenderPkg::rect_t r,
		input gpuRenderPkg::drawArea_t a, input logic mask);
		gpuRenderPkg::pixelWrite_t got;
		gpuRenderPkg::blockEvent_t endEv;
		int flushes;
		int nExp;
		buildExpected(r, a, mask);
		nExp = expQ.size();
		flushes = 0;
		@(negedge i_clk);
		i_rect = r;
		i_drawArea = a;
		i_checkMask = mask;
		i_start = 1'b1;
		@(negedge i_clk);
		i_start = 1'b0;
		do begin
			@(posedge i_clk);                         // End of cycle values
			got = o_pixelWrite;
			if (got.writeL || got.writeR) begin
				if (expQ.size() == 0) begin
					$display("%s wrote pair (%0d,%0d) that should stay untouched", name, got.x, got.y);
					errors++;
				end else checkPixelWrite(name, expQ.pop_front(), got);
			end else if (got.ev == gpuRenderPkg::EV_FLUSH_LAST) flushes++;
		end while (!o_renderInactiveNextCycle);
		if (expQ.size() != 0) begin
			$display("%s ended with %0d pair writes missing", name, expQ.size());
			errors++;
		end
		endEv = gpuRenderPkg::EV_NONE;
		if (nExp > 0) endEv = gpuRenderPkg::EV_FLUSH_LAST; // Flush shows with the pulse
		checkEvent(name, endEv, got.ev);
		if (flushes > 1) begin
			$display("%s gave %0d flush events instead of one", name, flushes);
			errors++;
		end
		@(posedge i_clk);
		if (o_busy !== 1'b0) begin
			$display("%s is still busy after the inactive pulse", name);
			errors++;
		end
	endtask

	task automatic reportTest(input string name);
		$display("%s: %s, %0d errors", name, (errors == testErrStart) ? "ok" : "failing",
			errors - testErrStart);
		testErrStart = errors;
		testsRun++;
	endtask

	// ----------------------------------------
	// Directed tests
	// ----------------------------------------
	task automatic fillWhole();
		runRect("fullFill", '{4, 2, 35, 9}, '{0, 0, 255, 63}, 1'b0);
		reportTest("fullFill");
	endtask

	task automatic clipEdges();
		runRect("clipArea", '{-5, 3, 40, 14}, '{7, 5, 30, 12}, 1'b0); // Odd left, even right
		runRect("clipRect", '{13, 20, 26, 24}, '{0, 0, 255, 63}, 1'b0);
		reportTest("clipping");
	endtask

	task automatic rejectEmpty();
		runRect("rejInverted", '{30, 5, 10, 9}, '{0, 0, 255, 63}, 1'b0);
		runRect("rejOutside", '{300, 5, 310, 9}, '{0, 0, 255, 63}, 1'b0);
		runRect("rejNegative", '{-20, -20, -5, -5}, '{0, 0, 255, 63}, 1'b0);
		reportTest("reject");
	endtask

	task automatic maskStencil();
		runRect("maskOn", '{2, 1, 41, 12}, '{0, 0, 255, 63}, 1'b1);
		runRect("maskOff", '{2, 1, 41, 12}, '{0, 0, 255, 63}, 1'b0);
		reportTest("mask");
	endtask

	task automatic stallMemory();
		busyMode = 1'b1;
		runRect("backPressure", '{2, 1, 41, 12}, '{0, 0, 255, 63}, 1'b1); // Same set as maskOn
		busyMode = 1'b0;
		reportTest("backPressure");
	endtask

	task automatic tagBlocks();
		runRect("blockSpan", '{0, 30, 70, 33}, '{0, 0, 255, 63}, 1'b1);
		runRect("allMasked", '{100, 40, 107, 40}, '{0, 0, 255, 63}, 1'b1);
		reportTest("blockEvents");
	endtask

	initial begin
		i_arstN = 1'b0;
		i_start = 1'b0;
		i_rect = '0;
		i_drawArea = '0;
		i_checkMask = 1'b0;
		i_memBusy = 1'b0;
		i_stencilValue = '0;
		for (int r = 0; r < 64; r++) begin
			for (int w = 0; w < 32; w++) begin
				rngState = xorshift(rngState);
				stencilMem[r][w * 32 +: 32] = rngState;
			end
		end
		stencilMem[40][107:100] = '1;               // Fully protected span
		repeat (16) @(posedge i_clk);
		@(negedge i_clk);
		i_arstN = 1'b1;
		fillWhole();
		clipEdges();
		rejectEmpty();
		maskStencil();
		stallMemory();
		tagBlocks();
		assertFails = i_gpuRectRender.u_gpuRectRenderAssert.failCount;
		$display("Tests run %0d, errors %0d, assertion failures %0d, cycles %0d", testsRun,
			errors, assertFails, cycleCount);
		if (errors == 0 && assertFails == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// File: src.f
src/gpuRenderPkg.sv
src/rectClipDecode.sv
src/rectScanFsm.sv
src/blockTracker.sv
src/gpuRectRender.sv
sim/gpuRectRender_assert.sv
sim/tbGpuRectRender.sv
